// ==== banked_slow_memory.f ====
+incdir+design
design/mem_addr_pkg.sv
design/mem_line_pkg.sv
design/bank_if.sv
design/bank_dispatch.sv
design/mem_bank.sv
design/resp_collect.sv
design/banked_slow_memory.sv
verif/banked_slow_memory_assertions.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_banked_slow_memory.sv

// ==== Bender.yml ====
package:
  name: banked_slow_memory

sources:
  - target: rtl
    include_dirs:
      - design
    files:
      - design/mem_addr_pkg.sv
      - design/mem_line_pkg.sv
      - design/bank_if.sv
      - design/bank_dispatch.sv
      - design/mem_bank.sv
      - design/resp_collect.sv
      - design/banked_slow_memory.sv
  - target: verif
    include_dirs:
      - design
    files:
      - verif/banked_slow_memory_assertions.sv
      - verif/tb_clkgen.sv
      - verif/tb_checker.sv
      - verif/tb_banked_slow_memory.sv

// ==== verif/tb_banked_slow_memory.sv ====
// inputs change 2 ns after the rising edge, tb_checker does all comparing
// random stimulus from $urandom with a fixed seed
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_banked_slow_memory;
    import mem_addr_pkg::*;
    import mem_line_pkg::*;

    localparam int RESP_TIMEOUT  = 20;
    localparam int DRAIN_TIMEOUT = 60;
    localparam int RESET_TIMEOUT = 40;
    localparam int RANDOM_COUNT  = 300;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_drop;
    logic       resp_valid;
    mem_op_t    req_op;
    mem_op_t    resp_op;
    line_addr_t req_addr;
    line_addr_t resp_addr;
    line_t      req_wdata;
    line_t      resp_rdata;
    int         test_id;
    int         value_errors;
    int         strobe_errors;
    int         pending;
    int         timeout_errors;

    tb_clkgen i_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    banked_slow_memory i_banked_slow_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_drop   (req_drop),
        .resp_valid (resp_valid),
        .resp_op    (resp_op),
        .resp_addr  (resp_addr),
        .resp_rdata (resp_rdata)
    );

    tb_checker i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_drop      (req_drop),
        .resp_valid    (resp_valid),
        .resp_op       (resp_op),
        .resp_addr     (resp_addr),
        .resp_rdata    (resp_rdata),
        .test_id       (test_id),
        .value_errors  (value_errors),
        .strobe_errors (strobe_errors),
        .pending       (pending)
    );

    function automatic line_t random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic line_addr_t random_addr();
        line_addr_t a;
        a.row  = row_t'($urandom);
        a.bank = bank_idx_t'($urandom);
        return a;
    endfunction

    // one-cycle strobe, returns 2 ns after the sampling edge
    task automatic issue(input mem_op_t op, input line_addr_t addr, input line_t data);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = data;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic skip_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_response();
        int waited;
        waited = 0;
        while (resp_valid !== 1'b1 && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (resp_valid !== 1'b1) begin
            timeout_errors++;
            $display("timeout: no resp_valid within %0d cycles in test %0d", RESP_TIMEOUT, test_id);
        end else begin
            skip_cycles(1);     // step past this strobe
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (pending != 0) begin
            timeout_errors++;
            $display("timeout: %0d expected strobes never seen in test %0d", pending, test_id);
        end
    endtask

    initial begin
        line_addr_t a;
        line_t      d;
        row_t       r;
        int         waited;
        int         assert_errors;
        req_valid      = 1'b0;
        req_op         = op_read;
        req_addr       = '0;
        req_wdata      = '0;
        test_id        = 0;
        timeout_errors = 0;
        void'($urandom(44721));

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeout_errors++;
            $display("timeout: reset was never released");
        end

        // quiet after reset, then reads of untouched lines
        test_id = 1;
        skip_cycles(6);
        repeat (8) begin
            issue(op_read, random_addr(), '0);
            wait_response();
        end

        test_id = 2;
        repeat (4) begin
            a = random_addr();
            d = random_line();
            issue(op_write, a, d);
            wait_response();
            issue(op_read, a, '0);
            wait_response();
        end

        // one request per cycle, one per bank
        test_id = 3;
        r = row_t'($urandom);
        for (int b = 0; b < `MEM_BANKS; b++) begin
            a.row  = r;
            a.bank = bank_idx_t'(b);
            issue(op_write, a, random_line());
        end
        repeat (`MEM_BANKS) wait_response();
        for (int b = 0; b < `MEM_BANKS; b++) begin
            a.row  = r;
            a.bank = bank_idx_t'(b);
            issue(op_read, a, '0);
        end
        repeat (`MEM_BANKS) wait_response();

        // writes at t+2 and t+5 hit the busy bank, the read at t+6 does not
        test_id = 4;
        a = random_addr();
        issue(op_write, a, random_line());
        skip_cycles(1);
        issue(op_write, a, random_line());
        skip_cycles(2);
        issue(op_write, a, random_line());
        issue(op_read, a, '0);
        wait_drained();

        test_id = 5;
        repeat (RANDOM_COUNT) begin
            a = random_addr();
            if ($urandom_range(1, 0) == 0)
                a.row = row_t'($urandom_range(7, 0));   // revisit a few rows
            issue(mem_op_t'($urandom_range(1, 0)), a, random_line());
            skip_cycles($urandom_range(3, 0));
        end
        wait_drained();

        assert_errors = i_banked_slow_memory.i_assertions.fail_count;
        $display("errors: value %0d, strobe %0d, timeout %0d, assertion %0d",
                 value_errors, strobe_errors, timeout_errors, assert_errors);
        if (value_errors + strobe_errors + timeout_errors + assert_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== verif/tb_checker.sv ====
// samples the top-level ports on the rising edge, memory assumed zero after reset
// one request per cycle, expectations come from the latency and busy window rules
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  mem_line_pkg::mem_op_t     req_op,
    input  mem_addr_pkg::line_addr_t  req_addr,
    input  mem_line_pkg::line_t       req_wdata,
    input  logic                      req_drop,
    input  logic                      resp_valid,
    input  mem_line_pkg::mem_op_t     resp_op,
    input  mem_addr_pkg::line_addr_t  resp_addr,
    input  mem_line_pkg::line_t       resp_rdata,
    input  int                        test_id,
    output int                        value_errors,
    output int                        strobe_errors,
    output int                        pending
);
    import mem_addr_pkg::*;
    import mem_line_pkg::*;

    localparam int RESP_DELAY = `MEM_LATENCY + 2;   // strobe to response
    localparam int BUSY_SPAN  = `MEM_LATENCY + 1;   // last sampling cycle that drops

    typedef struct packed {
        logic       accepted;
        int         due;
        int         tid;
        mem_op_t    op;
        line_addr_t addr;
        line_t      rdata;
    } expect_t;

    line_t   shadow [1 << $bits(line_addr_t)];
    int      busy_until [`MEM_BANKS];
    expect_t resp_q [$];
    expect_t drop_q [$];
    expect_t e;
    int      cyc;
    logic    was_reset = 1'b0;

    initial begin
        value_errors  = 0;
        strobe_errors = 0;
        pending       = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset_read";
            2:       return "write_read";
            3:       return "back_to_back";
            4:       return "busy_drop";
            5:       return "random_mix";
            default: return "idle";
        endcase
    endfunction

    // reference model, updates shadow state for every accepted request
    function automatic expect_t predict(input mem_op_t op, input line_addr_t addr,
                                        input line_t wdata, input int now, input int tid);
        expect_t r;
        r      = '0;
        r.tid  = tid;
        r.op   = op;
        r.addr = addr;
        if (now <= busy_until[addr.bank]) begin
            r.due = now + 1;    // drop strobe
        end else begin
            r.accepted = 1'b1;
            r.due      = now + RESP_DELAY;
            busy_until[addr.bank] = now + BUSY_SPAN;
            if (op == op_write)
                shadow[addr] = wdata;
            r.rdata = shadow[addr];
        end
        return r;
    endfunction

    task automatic compare(input string what, input int tid, input line_t exp, input line_t act);
        if (exp !== act) begin
            value_errors++;
            $display("Error %s: %s expected %0h actual %0h", test_name(tid), what, exp, act);
        end
    endtask

    task automatic check_outputs();
        expect_t x;
        if ($isunknown({req_drop, resp_valid})) begin
            strobe_errors++;
            $display("req_drop or resp_valid is unknown at cycle %0d", cyc);
        end
        if (drop_q.size() > 0 && drop_q[0].due == cyc) begin
            x = drop_q.pop_front();
            if (req_drop !== 1'b1) begin
                strobe_errors++;
                $display("missing req_drop for address %0h in test %s", x.addr, test_name(x.tid));
            end
        end else if (req_drop === 1'b1) begin
            strobe_errors++;
            $display("unexpected req_drop at cycle %0d in test %s", cyc, test_name(test_id));
        end
        if (resp_q.size() > 0 && resp_q[0].due == cyc) begin
            x = resp_q.pop_front();
            if (resp_valid !== 1'b1) begin
                strobe_errors++;
                $display("missing resp_valid for address %0h in test %s", x.addr, test_name(x.tid));
            end else begin
                compare("resp_op", x.tid, line_t'(x.op), line_t'(resp_op));
                compare("resp_addr", x.tid, line_t'(x.addr), line_t'(resp_addr));
                if (x.op == op_read)
                    compare("resp_rdata", x.tid, x.rdata, resp_rdata);
            end
        end else if (resp_valid === 1'b1) begin
            strobe_errors++;
            $display("unexpected resp_valid at cycle %0d in test %s", cyc, test_name(test_id));
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (was_reset && (req_drop !== 1'b0 || resp_valid !== 1'b0)) begin
                strobe_errors++;
                $display("req_drop or resp_valid active during reset");
            end
            was_reset = 1'b1;
            cyc       = 0;
            foreach (busy_until[b])
                busy_until[b] = -1;
            foreach (shadow[a])
                shadow[a] = '0;
            resp_q.delete();
            drop_q.delete();
        end else begin
            check_outputs();
            if (req_valid === 1'b1) begin
                e = predict(req_op, req_addr, req_wdata, cyc, test_id);
                if (e.accepted)
                    resp_q.push_back(e);
                else
                    drop_q.push_back(e);
            end
            cyc++;
        end
        pending = resp_q.size() + drop_q.size();
    end

endmodule

// ==== verif/tb_clkgen.sv ====
// 40 ns clock, rst_n held low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // released mid-cycle, first seen high on edge 11
    end

endmodule

// ==== verif/banked_slow_memory_assertions.sv ====
// bound to the RTL top, latency taken from the constants header
`timescale 1ns/1ps
`include "mem_consts.svh"

module banked_slow_memory_assertions (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_drop,
    input logic resp_valid
);
    localparam int RESP_DELAY = `MEM_LATENCY + 2;

    int fail_count = 0;

    // accepted means no drop strobe in the following cycle
    accepted_gets_response: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid ##1 !req_drop |-> ##(RESP_DELAY - 1) resp_valid)
        else begin
            fail_count++;
            $error("resp_valid missing 6 cycles after an accepted request");
        end

    strobes_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({req_drop, resp_valid}))
        else begin
            fail_count++;
            $error("req_drop or resp_valid unknown after reset");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !req_drop && !resp_valid)
        else begin
            fail_count++;
            $error("strobe active during reset");
        end

endmodule

bind banked_slow_memory banked_slow_memory_assertions i_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_drop   (req_drop),
    .resp_valid (resp_valid)
);

// ==== design/banked_slow_memory.sv ====
// fixed 6-cycle request to response latency with default constants
// no back-pressure, a request to a busy bank is lost
`timescale 1ns/1ps
`include "mem_consts.svh"

module banked_slow_memory (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  mem_line_pkg::mem_op_t     req_op,
    input  mem_addr_pkg::line_addr_t  req_addr,
    input  mem_line_pkg::line_t       req_wdata,
    output logic                      req_drop,
    output logic                      resp_valid,
    output mem_line_pkg::mem_op_t     resp_op,
    output mem_addr_pkg::line_addr_t  resp_addr,
    output mem_line_pkg::line_t       resp_rdata
);

    bank_if i_bank_if [`MEM_BANKS] ();

    bank_dispatch i_bank_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_drop  (req_drop),
        .banks     (i_bank_if)
    );

    for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank
        mem_bank i_mem_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .port  (i_bank_if[b])
        );
    end

    resp_collect i_resp_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .banks      (i_bank_if),
        .resp_valid (resp_valid),
        .resp_op    (resp_op),
        .resp_addr  (resp_addr),
        .resp_rdata (resp_rdata)
    );

endmodule

// ==== design/resp_collect.sv ====
// expects at most one bank done per cycle
`timescale 1ns/1ps
`include "mem_consts.svh"

module resp_collect (
    input  logic                      clk,
    input  logic                      rst_n,
    bank_if.collect                   banks [`MEM_BANKS],
    output logic                      resp_valid,
    output mem_line_pkg::mem_op_t     resp_op,
    output mem_addr_pkg::line_addr_t  resp_addr,
    output mem_line_pkg::line_t       resp_rdata
);
    import mem_addr_pkg::*;
    import mem_line_pkg::*;

    logic [`MEM_BANKS-1:0] done_vec;
    mem_op_t               op_a    [`MEM_BANKS];
    row_t                  row_a   [`MEM_BANKS];
    line_t                 rdata_a [`MEM_BANKS];
    mem_op_t               sel_op;
    line_addr_t            sel_addr;
    line_t                 sel_rdata;

    for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank_port
        assign done_vec[b] = banks[b].done;
        assign op_a[b]     = banks[b].done_op;
        assign row_a[b]    = banks[b].done_row;
        assign rdata_a[b]  = banks[b].rdata;
    end

    always_comb begin
        sel_op    = op_read;
        sel_addr  = '0;
        sel_rdata = '0;
        for (int b = 0; b < `MEM_BANKS; b++) begin
            if (done_vec[b]) begin
                sel_op        = op_a[b];
                sel_addr.row  = row_a[b];
                sel_addr.bank = bank_idx_t'(b);    // bank number back into low bits
                sel_rdata     = rdata_a[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            resp_valid <= 1'b0;
        else
            resp_valid <= |done_vec;
    end

    always_ff @(posedge clk) begin
        if (|done_vec) begin
            resp_op    <= sel_op;
            resp_addr  <= sel_addr;
            resp_rdata <= sel_rdata;
        end
    end

endmodule

// ==== design/mem_bank.sv ====
// one request at a time, done pulses MEM_LATENCY cycles after capture
// array is cleared by reset, which takes MEM_ROWS writes in one cycle
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_bank (
    input logic clk,
    input logic rst_n,
    bank_if.bank port
);
    import mem_addr_pkg::*;
    import mem_line_pkg::*;

    localparam int CNT_W = $clog2(`MEM_LATENCY);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_ready
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic             wait_last;
    logic             done_r;
    line_t            mem [`MEM_ROWS];
    mem_op_t          op_r;
    row_t             row_r;
    line_t            wdata_r;
    line_t            rdata_r;

    assign wait_last = (state == st_wait) && (cnt == CNT_W'(`MEM_LATENCY - 2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            cnt    <= '0;
            done_r <= 1'b0;
            for (int r = 0; r < `MEM_ROWS; r++) begin
                mem[r] <= '0;
            end
        end else begin
            done_r <= 1'b0;
            case (state)
                st_idle: begin
                    if (port.req) begin
                        state <= st_wait;
                        cnt   <= '0;
                    end
                end
                st_wait: begin
                    if (wait_last) begin
                        state  <= st_ready;
                        done_r <= 1'b1;
                        if (op_r == op_write)
                            mem[row_r] <= wdata_r;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;  // ready lasts one cycle
            endcase
        end
    end

    // captured request and read line
    always_ff @(posedge clk) begin
        if (state == st_idle && port.req) begin
            op_r    <= port.op;
            row_r   <= port.row;
            wdata_r <= port.wdata;
        end
        if (wait_last && op_r == op_read)
            rdata_r <= mem[row_r];
    end

    assign port.busy     = (state != st_idle);
    assign port.done     = done_r;
    assign port.done_op  = op_r;
    assign port.done_row = row_r;
    assign port.rdata    = rdata_r;

endmodule

// ==== design/bank_dispatch.sv ====
// requests to a busy bank are dropped and only req_drop reports them
`timescale 1ns/1ps
`include "mem_consts.svh"

module bank_dispatch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  mem_line_pkg::mem_op_t     req_op,
    input  mem_addr_pkg::line_addr_t  req_addr,
    input  mem_line_pkg::line_t       req_wdata,
    output logic                      req_drop,
    bank_if.dispatch                  banks [`MEM_BANKS]
);
    import mem_addr_pkg::*;
    import mem_line_pkg::*;

    logic [`MEM_BANKS-1:0] busy_vec;
    logic [`MEM_BANKS-1:0] sel_oh;
    logic [`MEM_BANKS-1:0] req_oh;      // registered one-hot request
    logic                  target_busy;
    mem_op_t               op_r;
    row_t                  row_r;
    line_t                 wdata_r;

    assign sel_oh = `MEM_BANKS'(1) << req_addr.bank;

    // a request still in flight to the bank counts as busy too
    assign target_busy = |(sel_oh & (busy_vec | req_oh));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_oh   <= '0;
            req_drop <= 1'b0;
        end else begin
            req_oh   <= (req_valid && !target_busy) ? sel_oh : '0;
            req_drop <= req_valid && target_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && !target_busy) begin
            op_r    <= req_op;
            row_r   <= req_addr.row;
            wdata_r <= req_wdata;
        end
    end

    for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank_port
        assign busy_vec[b]    = banks[b].busy;
        assign banks[b].req   = req_oh[b];
        assign banks[b].op    = op_r;       // payload shared by all banks
        assign banks[b].row   = row_r;
        assign banks[b].wdata = wdata_r;
    end

endmodule

// ==== design/bank_if.sv ====
// one bank's request and completion, strobes only, no back-pressure
`timescale 1ns/1ps

interface bank_if;
    import mem_addr_pkg::*;
    import mem_line_pkg::*;

    logic    req;       // one-cycle request strobe
    mem_op_t op;
    row_t    row;
    line_t   wdata;

    logic    busy;
    logic    done;      // one-cycle completion strobe
    mem_op_t done_op;
    row_t    done_row;
    line_t   rdata;

    modport dispatch (output req, op, row, wdata, input busy);

    modport bank (
        input  req, op, row, wdata,
        output busy, done, done_op, done_row, rdata
    );

    modport collect (input done, done_op, done_row, rdata);

endinterface

// ==== design/mem_line_pkg.sv ====
// payload types, one full line per request
// a request is either a read or a write, never both
package mem_line_pkg;

`include "mem_consts.svh"

    // one memory line
    typedef logic [`MEM_LINE_W-1:0] line_t;

    typedef enum logic {
        op_read,
        op_write
    } mem_op_t;

endpackage

// ==== design/mem_addr_pkg.sv ====
// line addressing only, byte and word offsets are not modelled
// the bank field sits in the low address bits
package mem_addr_pkg;

`include "mem_consts.svh"

    // bank select
    typedef logic [$clog2(`MEM_BANKS)-1:0] bank_idx_t;

    // row inside one bank
    typedef logic [$clog2(`MEM_ROWS)-1:0] row_t;

    // full line address, bank in the low bits
    typedef struct packed {
        row_t      row;
        bank_idx_t bank;
    } line_addr_t;

endpackage

// ==== design/mem_consts.svh ====
// MEM_BANKS must be a power of two
// MEM_LATENCY must be 2 or more for the bank counter to work
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// number of banks
`define MEM_BANKS 4

// lines held in each bank
`define MEM_ROWS 256

// one line is four 32-bit words
`define MEM_LINE_W 128

// cycles from bank capture to the ready pulse
`define MEM_LATENCY 4

`endif
